// ==== include/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

`define CACHE_ADDR_W      32
`define CACHE_L1_INDEX_W  2
`define CACHE_L2_INDEX_W  3
`define CACHE_OFFSET_W    2   // 4 words per line
`define CACHE_BYTE_OFF_W  2
`define CACHE_LINE_W      128

`define CACHE_L1_TAG_W (`CACHE_ADDR_W - `CACHE_L1_INDEX_W - `CACHE_OFFSET_W - `CACHE_BYTE_OFF_W)
`define CACHE_L2_TAG_W (`CACHE_ADDR_W - `CACHE_L2_INDEX_W - `CACHE_OFFSET_W - `CACHE_BYTE_OFF_W)

`define CACHE_L1_SETS (1 << `CACHE_L1_INDEX_W)
`define CACHE_L2_SETS (1 << `CACHE_L2_INDEX_W)

`endif

// ==== source/cache_pkg.sv ====
`include "cache_defs.svh"

package cache_pkg;

    typedef struct packed {
        logic [`CACHE_L1_TAG_W-1:0]   tag;
        logic [`CACHE_L1_INDEX_W-1:0] index;
        logic [`CACHE_OFFSET_W-1:0]   word;
        logic [`CACHE_BYTE_OFF_W-1:0] byte_off;
    } l1_addr_t;

    typedef struct packed {
        logic [`CACHE_L2_TAG_W-1:0]   tag;
        logic [`CACHE_L2_INDEX_W-1:0] index;
        logic [`CACHE_OFFSET_W-1:0]   word;
        logic [`CACHE_BYTE_OFF_W-1:0] byte_off;
    } l2_addr_t;

    // one address, split differently by each level
    typedef union packed {
        l1_addr_t l1;
        l2_addr_t l2;
    } cache_addr_u;

    typedef logic [`CACHE_LINE_W-1:0] cache_line_t;

    typedef enum logic [1:0] {
        REQ_READ  = 2'd0,
        REQ_WRITE = 2'd1,
        REQ_FLUSH = 2'd2
    } req_kind_e;

    typedef struct packed {
        req_kind_e   kind;
        cache_addr_u addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } l1_req_t;

endpackage

// ==== source/set_sweep_counter.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module set_sweep_counter (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         sweep_clear,
    input  logic                         sweep_step,
    output logic [`CACHE_L2_INDEX_W-1:0] sweep_index,
    output logic                         sweep_last
);
    assign sweep_last = sweep_index == '1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            sweep_index <= '0;
        else if (sweep_clear)
            sweep_index <= '0;
        else if (sweep_step)
            sweep_index <= sweep_index + 1'b1;
    end

endmodule

// ==== source/l2_array.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module l2_array
    import cache_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  cache_addr_u                sel_addr,
    input  logic                       array_fill,
    input  logic                       array_write,
    input  logic                       array_clean,
    input  cache_line_t                fill_line,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 wstrb,
    output logic                       hit,
    output logic                       victim_dirty,
    output logic [`CACHE_L2_TAG_W-1:0] victim_tag,
    output cache_line_t                rd_line
);
    logic [`CACHE_L2_SETS-1:0]    valid;
    logic [`CACHE_L2_SETS-1:0]    dirty;
    logic [`CACHE_L2_TAG_W-1:0]   tags [`CACHE_L2_SETS];
    cache_line_t                  lines [`CACHE_L2_SETS];
    logic [`CACHE_L2_INDEX_W-1:0] idx;

    assign idx          = sel_addr.l2.index;
    assign hit          = valid[idx] && tags[idx] == sel_addr.l2.tag;
    assign victim_dirty = valid[idx] && dirty[idx];
    assign victim_tag   = tags[idx];
    assign rd_line      = lines[idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
            dirty <= '0;
        end else if (array_fill) begin
            valid[idx] <= 1'b1;
            dirty[idx] <= 1'b0;   // fresh from memory
        end else if (array_write) begin
            dirty[idx] <= 1'b1;
        end else if (array_clean) begin
            dirty[idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (array_fill) begin
            lines[idx] <= fill_line;
            tags[idx]  <= sel_addr.l2.tag;
        end else if (array_write) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b])
                    lines[idx][sel_addr.l2.word*32 + b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

endmodule

// ==== source/l2_ctrl_fsm.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module l2_ctrl_fsm
    import cache_pkg::*;
(
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         icache_l2cache_req,
    input  l1_req_t                      req_icache_l2cache,
    output logic                         l2cache_icache_addrOK,
    output logic                         l2cache_icache_dataOK,
    output cache_line_t                  dout_l2cache_icache,
    input  logic                         dcache_l2cache_req,
    input  l1_req_t                      req_dcache_l2cache,
    output logic                         l2cache_dcache_addrOK,
    output logic                         l2cache_dcache_dataOK,
    output cache_line_t                  dout_l2cache_dcache,
    output logic [`CACHE_ADDR_W-1:0]     addr_l2cache_mem_r,
    output logic [`CACHE_ADDR_W-1:0]     addr_l2cache_mem_w,
    output cache_line_t                  dout_l2cache_mem,
    output logic                         l2cache_mem_req_r,
    output logic                         l2cache_mem_req_w,
    output logic                         l2cache_mem_rdy,
    output logic [3:0]                   l2cache_mem_wstrb,
    input  logic                         mem_l2cache_addrOK_r,
    input  logic                         mem_l2cache_addrOK_w,
    input  logic                         mem_l2cache_dataOK,
    input  logic                         hit,
    input  logic                         victim_dirty,
    input  logic [`CACHE_L2_TAG_W-1:0]   victim_tag,
    input  cache_line_t                  rd_line,
    input  logic                         sweep_last,
    input  logic [`CACHE_L2_INDEX_W-1:0] sweep_index,
    output logic                         sweep_step,
    output logic                         sweep_clear,
    output logic                         array_fill,
    output logic                         array_write,
    output logic                         array_clean,
    output cache_addr_u                  sel_addr
);
    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_LOOKUP  = 3'd1;
    localparam logic [2:0] S_EVICT   = 3'd2;
    localparam logic [2:0] S_FILL    = 3'd3;
    localparam logic [2:0] S_RESPOND = 3'd4;
    localparam logic [2:0] S_SWEEP   = 3'd5;

    logic [2:0]  state;
    logic        grant_d;
    logic        mem_acc;   // address taken, waiting for dataOK
    l1_req_t     req_q;
    l1_req_t     req_in;
    logic        any_req;
    logic        writing_back;
    logic        mem_done;
    cache_addr_u addr_r;
    cache_addr_u addr_w;

    assign any_req = icache_l2cache_req || dcache_l2cache_req;
    assign req_in  = dcache_l2cache_req ? req_dcache_l2cache : req_icache_l2cache;

    // data side wins a tie
    assign l2cache_dcache_addrOK = state == S_IDLE && dcache_l2cache_req;
    assign l2cache_icache_addrOK = state == S_IDLE && icache_l2cache_req && !dcache_l2cache_req;
    assign l2cache_dcache_dataOK = state == S_RESPOND && grant_d;
    assign l2cache_icache_dataOK = state == S_RESPOND && !grant_d;
    assign dout_l2cache_icache   = rd_line;
    assign dout_l2cache_dcache   = rd_line;

    always_comb begin
        sel_addr = req_q.addr;
        if (state == S_SWEEP)
            sel_addr.l2.index = sweep_index;
        addr_r = sel_addr;
        addr_r.l2.word = '0;
        addr_r.l2.byte_off = '0;
        addr_w = addr_r;
        addr_w.l2.tag = victim_tag;
    end

    assign writing_back = state == S_EVICT || (state == S_SWEEP && victim_dirty);
    assign mem_done     = mem_acc && mem_l2cache_dataOK;

    assign addr_l2cache_mem_r = addr_r;
    assign addr_l2cache_mem_w = addr_w;
    assign dout_l2cache_mem   = rd_line;
    assign l2cache_mem_wstrb  = 4'b1111;
    assign l2cache_mem_req_w  = writing_back && !mem_acc;
    assign l2cache_mem_req_r  = state == S_FILL && !mem_acc;
    assign l2cache_mem_rdy    = state == S_FILL && mem_acc;

    assign array_fill  = state == S_FILL && mem_done;
    assign array_write = state == S_LOOKUP && hit && req_q.kind == REQ_WRITE;
    assign array_clean = state == S_SWEEP && mem_done;
    assign sweep_clear = state == S_IDLE && any_req && req_in.kind == REQ_FLUSH;
    assign sweep_step  = state == S_SWEEP && !victim_dirty && !sweep_last;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_IDLE;
            grant_d <= 1'b0;
            mem_acc <= 1'b0;
        end else begin
            if ((l2cache_mem_req_r && mem_l2cache_addrOK_r) ||
                (l2cache_mem_req_w && mem_l2cache_addrOK_w))
                mem_acc <= 1'b1;
            else if (mem_done)
                mem_acc <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (any_req) begin
                        grant_d <= dcache_l2cache_req;
                        state   <= (req_in.kind == REQ_FLUSH) ? S_SWEEP : S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (hit)
                        state <= S_RESPOND;
                    else if (victim_dirty)
                        state <= S_EVICT;
                    else
                        state <= S_FILL;
                end
                S_EVICT: begin
                    if (mem_done)
                        state <= S_FILL;
                end
                S_FILL: begin
                    if (mem_done)
                        state <= S_LOOKUP;   // second lookup hits, then a write merges
                end
                S_SWEEP: begin
                    if (!victim_dirty && sweep_last)
                        state <= S_RESPOND;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && any_req)
            req_q <= req_in;
    end

    // refilled line must be present for the second lookup
    assert property (@(posedge clk) disable iff (!arst_n)
        state == S_FILL && mem_done |=> hit);

    assert property (@(posedge clk) disable iff (!arst_n)
        array_clean |=> !victim_dirty);   // written-back set reads clean

endmodule

// ==== source/icache.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module icache
    import cache_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [`CACHE_ADDR_W-1:0] addr_pipeline_icache,
    input  logic                     pipeline_icache_valid,
    input  logic                     pipeline_icache_opflag,
    output logic                     icache_pipeline_ready,
    output logic                     icache_pipeline_done,
    output logic [63:0]              dout_icache_pipeline,
    output logic [`CACHE_ADDR_W-1:0] pc_icache_pipeline,
    output logic                     flag_icache_pipeline,
    output logic                     icache_l2cache_req,
    output l1_req_t                  req_icache_l2cache,
    input  logic                     l2cache_icache_addrOK,
    input  logic                     l2cache_icache_dataOK,
    input  cache_line_t              dout_l2cache_icache
);
    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_LOOKUP = 3'd1;
    localparam logic [2:0] S_REQ    = 3'd2;
    localparam logic [2:0] S_WAIT   = 3'd3;
    localparam logic [2:0] S_RESP   = 3'd4;

    logic [2:0]                 state;
    logic                       op_q;
    cache_addr_u                addr_q;
    logic [`CACHE_L1_SETS-1:0]  valid;
    logic [`CACHE_L1_TAG_W-1:0] tags [`CACHE_L1_SETS];
    cache_line_t                lines [`CACHE_L1_SETS];
    cache_line_t                cur_line;
    logic [`CACHE_OFFSET_W-1:0] next_word;
    logic                       hit;

    assign cur_line  = lines[addr_q.l1.index];
    assign hit       = valid[addr_q.l1.index] && tags[addr_q.l1.index] == addr_q.l1.tag;
    assign next_word = addr_q.l1.word + 1'b1;   // wraps at offset 3, flag covers it

    assign icache_pipeline_ready = state == S_IDLE;
    assign icache_pipeline_done  = (state == S_LOOKUP && (op_q || hit)) || state == S_RESP;
    assign dout_icache_pipeline  = {cur_line[next_word*32 +: 32],
                                    cur_line[addr_q.l1.word*32 +: 32]};
    assign pc_icache_pipeline    = addr_q;
    assign flag_icache_pipeline  = addr_q.l1.word != '1;

    assign icache_l2cache_req = state == S_REQ;
    assign req_icache_l2cache = '{kind: REQ_READ, addr: addr_q, wdata: '0, wstrb: '0};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            op_q  <= 1'b0;
            valid <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (pipeline_icache_valid) begin
                        state <= S_LOOKUP;
                        op_q  <= pipeline_icache_opflag;
                        if (pipeline_icache_opflag)
                            valid <= '0;   // invalidate all
                    end
                end
                S_LOOKUP: state <= (op_q || hit) ? S_IDLE : S_REQ;
                S_REQ: begin
                    if (l2cache_icache_addrOK)
                        state <= S_WAIT;
                end
                S_WAIT: begin
                    if (l2cache_icache_dataOK) begin
                        state <= S_RESP;
                        valid[addr_q.l1.index] <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (icache_pipeline_ready && pipeline_icache_valid)
            addr_q <= addr_pipeline_icache;
        if (state == S_WAIT && l2cache_icache_dataOK) begin
            lines[addr_q.l1.index] <= dout_l2cache_icache;
            tags[addr_q.l1.index]  <= addr_q.l1.tag;
        end
    end

    // request must hold until L2 takes it
    assert property (@(posedge clk) disable iff (!arst_n)
        icache_l2cache_req && !l2cache_icache_addrOK |=>
            icache_l2cache_req && $stable(req_icache_l2cache));

endmodule

// ==== source/dcache.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module dcache
    import cache_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [`CACHE_ADDR_W-1:0] addr_pipeline_dcache,
    input  logic [31:0]              din_pipeline_dcache,
    input  logic                     type_pipeline_dcache,
    input  logic [3:0]               pipeline_dcache_wstrb,
    input  logic                     pipeline_dcache_valid,
    input  logic                     pipeline_dcache_opflag,
    output logic                     dcache_pipeline_ready,
    output logic                     dcache_pipeline_done,
    output logic [31:0]              dout_dcache_pipeline,
    output logic                     dcache_l2cache_req,
    output l1_req_t                  req_dcache_l2cache,
    input  logic                     l2cache_dcache_addrOK,
    input  logic                     l2cache_dcache_dataOK,
    input  cache_line_t              dout_l2cache_dcache
);
    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_LOOKUP = 3'd1;
    localparam logic [2:0] S_REQ    = 3'd2;
    localparam logic [2:0] S_WAIT   = 3'd3;
    localparam logic [2:0] S_RESP   = 3'd4;

    logic [2:0]                 state;
    logic                       op_q;
    logic                       write_q;
    cache_addr_u                addr_q;
    logic [31:0]                din_q;
    logic [3:0]                 wstrb_q;
    logic [`CACHE_L1_SETS-1:0]  valid;
    logic [`CACHE_L1_TAG_W-1:0] tags [`CACHE_L1_SETS];
    cache_line_t                lines [`CACHE_L1_SETS];
    logic                       hit;
    logic                       is_read;

    assign hit     = valid[addr_q.l1.index] && tags[addr_q.l1.index] == addr_q.l1.tag;
    assign is_read = !op_q && !write_q;

    assign dcache_pipeline_ready = state == S_IDLE;
    assign dcache_pipeline_done  = (state == S_LOOKUP && is_read && hit) || state == S_RESP;
    assign dout_dcache_pipeline  = lines[addr_q.l1.index][addr_q.l1.word*32 +: 32];

    assign dcache_l2cache_req = state == S_REQ;
    assign req_dcache_l2cache = '{
        kind:  op_q ? REQ_FLUSH : (write_q ? REQ_WRITE : REQ_READ),
        addr:  addr_q,
        wdata: din_q,
        wstrb: wstrb_q
    };

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_IDLE;
            op_q    <= 1'b0;
            write_q <= 1'b0;
            valid   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (pipeline_dcache_valid) begin
                        state   <= S_LOOKUP;
                        op_q    <= pipeline_dcache_opflag;
                        write_q <= type_pipeline_dcache;
                        if (pipeline_dcache_opflag)
                            valid <= '0;
                    end
                end
                S_LOOKUP: state <= (is_read && hit) ? S_IDLE : S_REQ;
                S_REQ: begin
                    if (l2cache_dcache_addrOK)
                        state <= S_WAIT;
                end
                S_WAIT: begin
                    if (l2cache_dcache_dataOK) begin
                        state <= S_RESP;
                        if (is_read)
                            valid[addr_q.l1.index] <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dcache_pipeline_ready && pipeline_dcache_valid) begin
            addr_q  <= addr_pipeline_dcache;
            din_q   <= din_pipeline_dcache;
            wstrb_q <= pipeline_dcache_wstrb;
        end
        // write hit updates the local copy, a miss does not allocate
        if (state == S_LOOKUP && write_q && !op_q && hit) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb_q[b])
                    lines[addr_q.l1.index][addr_q.l1.word*32 + b*8 +: 8] <= din_q[b*8 +: 8];
            end
        end
        if (state == S_WAIT && l2cache_dcache_dataOK && is_read) begin
            lines[addr_q.l1.index] <= dout_l2cache_dcache;
            tags[addr_q.l1.index]  <= addr_q.l1.tag;
        end
    end

endmodule

// ==== source/l1_l2_cache.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module l1_l2_cache
    import cache_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic [`CACHE_ADDR_W-1:0] addr_pipeline_icache,
    output logic [63:0]              dout_icache_pipeline,   // [31:0] is the addressed word
    output logic [`CACHE_ADDR_W-1:0] pc_icache_pipeline,
    output logic                     flag_icache_pipeline,
    input  logic                     pipeline_icache_valid,
    output logic                     icache_pipeline_ready,
    input  logic                     pipeline_icache_opflag,
    output logic                     icache_pipeline_done,

    input  logic [`CACHE_ADDR_W-1:0] addr_pipeline_dcache,
    input  logic [31:0]              din_pipeline_dcache,
    output logic [31:0]              dout_dcache_pipeline,
    input  logic                     type_pipeline_dcache,   // 0 read, 1 write
    input  logic                     pipeline_dcache_valid,
    output logic                     dcache_pipeline_ready,
    input  logic [3:0]               pipeline_dcache_wstrb,
    input  logic                     pipeline_dcache_opflag,
    output logic                     dcache_pipeline_done,

    output logic [`CACHE_ADDR_W-1:0] addr_l2cache_mem_r,
    output logic [`CACHE_ADDR_W-1:0] addr_l2cache_mem_w,
    input  cache_line_t              din_mem_l2cache,
    output cache_line_t              dout_l2cache_mem,
    output logic                     l2cache_mem_req_r,
    output logic                     l2cache_mem_req_w,
    output logic                     l2cache_mem_rdy,
    output logic [3:0]               l2cache_mem_wstrb,
    input  logic                     mem_l2cache_addrOK_r,
    input  logic                     mem_l2cache_addrOK_w,
    input  logic                     mem_l2cache_dataOK
);
    logic        icache_l2cache_req;
    l1_req_t     req_icache_l2cache;
    logic        l2cache_icache_addrOK;
    logic        l2cache_icache_dataOK;
    cache_line_t dout_l2cache_icache;

    logic        dcache_l2cache_req;
    l1_req_t     req_dcache_l2cache;
    logic        l2cache_dcache_addrOK;
    logic        l2cache_dcache_dataOK;
    cache_line_t dout_l2cache_dcache;

    logic                        hit;
    logic                        victim_dirty;
    logic [`CACHE_L2_TAG_W-1:0]  victim_tag;
    cache_line_t                 rd_line;
    cache_addr_u                 sel_addr;
    logic                        array_fill;
    logic                        array_write;
    logic                        array_clean;
    logic                        sweep_step;
    logic                        sweep_clear;
    logic                        sweep_last;
    logic [`CACHE_L2_INDEX_W-1:0] sweep_index;

    icache u_icache (.*);

    dcache u_dcache (.*);

    l2_ctrl_fsm u_l2_ctrl_fsm (.*);

    set_sweep_counter u_set_sweep_counter (.*);

    // only the data side writes into L2
    l2_array u_l2_array (
        .fill_line (din_mem_l2cache),
        .wdata     (req_dcache_l2cache.wdata),
        .wstrb     (req_dcache_l2cache.wstrb),
        .*
    );

endmodule

// ==== tests/mem_model.sv ====
`timescale 1ns/1ps

module mem_model
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] addr_r,
    input  logic [31:0] addr_w,
    output cache_line_t din,
    input  cache_line_t dout,
    input  logic        req_r,
    input  logic        req_w,
    input  logic        rdy,
    input  logic [3:0]  wstrb,
    output logic        addrOK_r,
    output logic        addrOK_w,
    output logic        dataOK,
    input  cache_line_t exp_line,   // shadow copy of the line at addr_w
    output int          errors
);
    cache_line_t store [int unsigned];   // keyed by line address

    // untouched words hold their address with the upper half inverted
    function automatic cache_line_t line_at(input logic [31:0] a);
        cache_line_t l;
        logic [31:0] w;
        if (store.exists(a >> 4))
            return store[a >> 4];
        for (int i = 0; i < 4; i++) begin
            w = {a[31:4], i[1:0], 2'b00};
            l[i*32 +: 32] = {~w[31:16], w[15:0]};
        end
        return l;
    endfunction

    task automatic phase_delay();
        repeat ($urandom_range(8, 1)) @(posedge clk);
    endtask

    initial begin
        addrOK_r = 1'b0;
        addrOK_w = 1'b0;
        dataOK   = 1'b0;
        din      = '0;
        errors   = 0;
        forever begin
            @(negedge clk);
            if (arst_n && req_r) begin
                phase_delay();
                addrOK_r <= 1'b1;
                @(posedge clk);
                addrOK_r <= 1'b0;
                do @(negedge clk); while (!rdy);
                phase_delay();
                din    <= line_at(addr_r);
                dataOK <= 1'b1;
                @(posedge clk);
                dataOK <= 1'b0;
            end else if (arst_n && req_w) begin
                store[addr_w >> 4] = dout;   // held stable until addrOK_w
                phase_delay();
                addrOK_w <= 1'b1;
                @(posedge clk);
                addrOK_w <= 1'b0;
                phase_delay();
                dataOK <= 1'b1;
                @(posedge clk);
                dataOK <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        req_w && addrOK_w |-> dout == exp_line)
    else begin
        errors++;
        $display("** Error: dout_l2cache_mem %h expected %h",
                 $sampled(dout), $sampled(exp_line));
    end

    assert property (@(posedge clk) disable iff (!arst_n) req_w |-> wstrb == 4'hf)
    else begin
        errors++;
        $display("** Error: l2cache_mem_wstrb %h expected f", $sampled(wstrb));
    end

endmodule

// ==== tests/tb_l1_l2_cache.sv ====
`timescale 1ns/1ps

module tb_l1_l2_cache
    import cache_pkg::*;
();
    localparam int N_OPS = 178;
    localparam int LIMIT = N_OPS * 40;

    logic clk, arst_n;
    logic [31:0] addr_pipeline_icache, addr_pipeline_dcache, din_pipeline_dcache;
    logic [31:0] pc_icache_pipeline, dout_dcache_pipeline;
    logic [63:0] dout_icache_pipeline;
    logic flag_icache_pipeline, pipeline_icache_valid, icache_pipeline_ready;
    logic pipeline_icache_opflag, icache_pipeline_done;
    logic type_pipeline_dcache, pipeline_dcache_valid, dcache_pipeline_ready;
    logic pipeline_dcache_opflag, dcache_pipeline_done;
    logic [3:0] pipeline_dcache_wstrb, l2cache_mem_wstrb;
    logic [31:0] addr_l2cache_mem_r, addr_l2cache_mem_w;
    cache_line_t din_mem_l2cache, dout_l2cache_mem, exp_line;
    logic l2cache_mem_req_r, l2cache_mem_req_w, l2cache_mem_rdy;
    logic mem_l2cache_addrOK_r, mem_l2cache_addrOK_w, mem_l2cache_dataOK;

    logic [7:0]  shadow [int unsigned];
    int unsigned written[$];   // line addresses touched by stores
    logic [63:0] exp_i;
    logic [31:0] exp_d, exp_pc;
    logic        i_op, d_check;
    int          errors, mem_errors, cycles;

    l1_l2_cache u_dut (.*);

    mem_model u_mem (
        .clk(clk), .arst_n(arst_n), .addr_r(addr_l2cache_mem_r), .addr_w(addr_l2cache_mem_w),
        .din(din_mem_l2cache), .dout(dout_l2cache_mem), .req_r(l2cache_mem_req_r),
        .req_w(l2cache_mem_req_w), .rdy(l2cache_mem_rdy), .wstrb(l2cache_mem_wstrb),
        .addrOK_r(mem_l2cache_addrOK_r), .addrOK_w(mem_l2cache_addrOK_w),
        .dataOK(mem_l2cache_dataOK), .exp_line(exp_line), .errors(mem_errors)
    );

    function automatic logic [7:0] shadow_byte(input logic [31:0] a);
        logic [31:0] w;
        w = {a[31:2], 2'b00};
        w = {~w[31:16], w[15:0]};
        return shadow.exists(a) ? shadow[a] : w[a[1:0]*8 +: 8];
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        return {shadow_byte(a + 3), shadow_byte(a + 2), shadow_byte(a + 1), shadow_byte(a)};
    endfunction

    function automatic cache_line_t shadow_line(input logic [31:0] a);
        cache_line_t l;
        for (int i = 0; i < 4; i++)
            l[i*32 +: 32] = shadow_word({a[31:4], 4'h0} + 4 * i);
        return l;
    endfunction

    task automatic fetch(input logic [31:0] a, input logic inval);
        @(posedge clk);
        exp_i  = {shadow_word(a + 4), shadow_word(a)};
        exp_pc = a;
        i_op   = inval;
        addr_pipeline_icache   <= a;
        pipeline_icache_opflag <= inval;
        pipeline_icache_valid  <= 1'b1;
        @(posedge clk);
        pipeline_icache_valid <= 1'b0;
        do @(negedge clk); while (!icache_pipeline_done);
    endtask

    task automatic data_op(input logic [31:0] a, input logic wr, input logic [31:0] d,
                           input logic [3:0] strb, input logic op);
        @(posedge clk);
        if (wr) begin
            for (int b = 0; b < 4; b++)
                if (strb[b])
                    shadow[a + b] = d[b*8 +: 8];
            written.push_back(a >> 4);
        end
        exp_d   = shadow_word(a);
        d_check = !wr && !op;
        addr_pipeline_dcache   <= a;
        din_pipeline_dcache    <= d;
        pipeline_dcache_wstrb  <= strb;
        type_pipeline_dcache   <= wr;
        pipeline_dcache_opflag <= op;
        pipeline_dcache_valid  <= 1'b1;
        @(posedge clk);
        pipeline_dcache_valid <= 1'b0;
        do @(negedge clk); while (!dcache_pipeline_done);
    endtask

    always @(negedge clk)
        exp_line = shadow_line(addr_l2cache_mem_w);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Errors found");
            $display("timeout, no completion within %0d cycles", LIMIT);
            $finish;
        end
    end

    assert property (@(posedge clk) $rose(arst_n) |-> icache_pipeline_ready &&
        dcache_pipeline_ready && !l2cache_mem_req_r && !l2cache_mem_req_w &&
        !icache_pipeline_done && !dcache_pipeline_done)
    else begin
        errors++;
        $display("reset state wrong: ready, req or done outputs not at idle values");
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        icache_pipeline_done && !i_op |-> dout_icache_pipeline[31:0] == exp_i[31:0])
    else begin
        errors++;
        $display("** Error: dout_icache_pipeline[31:0] %h expected %h",
                 $sampled(dout_icache_pipeline[31:0]), $sampled(exp_i[31:0]));
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        icache_pipeline_done && !i_op && exp_pc[3:2] != 2'd3 |->
            dout_icache_pipeline[63:32] == exp_i[63:32])
    else begin
        errors++;
        $display("** Error: dout_icache_pipeline[63:32] %h expected %h",
                 $sampled(dout_icache_pipeline[63:32]), $sampled(exp_i[63:32]));
    end

    // next word lives in another line at offset 3
    assert property (@(posedge clk) disable iff (!arst_n)
        icache_pipeline_done && !i_op |-> flag_icache_pipeline == (exp_pc[3:2] != 2'd3))
    else begin
        errors++;
        $display("** Error: flag_icache_pipeline %h for pc %h",
                 $sampled(flag_icache_pipeline), $sampled(exp_pc));
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        icache_pipeline_done |-> pc_icache_pipeline == exp_pc)
    else begin
        errors++;
        $display("** Error: pc_icache_pipeline %h expected %h",
                 $sampled(pc_icache_pipeline), $sampled(exp_pc));
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        dcache_pipeline_done && d_check |-> dout_dcache_pipeline == exp_d)
    else begin
        errors++;
        $display("** Error: dout_dcache_pipeline %h expected %h",
                 $sampled(dout_dcache_pipeline), $sampled(exp_d));
    end

    initial begin
        logic [31:0] a, b;
        void'($urandom(29456));
        errors = 0;
        cycles = 0;
        i_op = 1'b0;
        d_check = 1'b0;
        exp_i = '0;
        exp_d = '0;
        exp_pc = '0;
        arst_n = 1'b0;
        addr_pipeline_icache = '0;
        pipeline_icache_valid = 1'b0;
        pipeline_icache_opflag = 1'b0;
        addr_pipeline_dcache = '0;
        din_pipeline_dcache = '0;
        type_pipeline_dcache = 1'b0;
        pipeline_dcache_wstrb = '0;
        pipeline_dcache_valid = 1'b0;
        pipeline_dcache_opflag = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < 16; i++)
            fetch(32'h2000 + 4 * i, 1'b0);

        repeat (40) begin
            a = 32'h1000 | ($urandom & 32'hfc);
            b = 32'h1000 | ($urandom & 32'hfc);
            data_op(a, 1'b1, $urandom, $urandom_range(15, 1), 1'b0);
            data_op(b, 1'b0, '0, '0, 1'b0);
            data_op(a, 1'b0, '0, '0, 1'b0);
        end

        repeat (8) begin   // both sides compete for L2
            a = 32'h2000 | ($urandom & 32'hfc);
            b = 32'h1000 | ($urandom & 32'hfc);
            fork
                fetch(a, 1'b0);
                data_op(b, 1'b0, '0, '0, 1'b0);
            join
        end

        // same L2 set, different tags
        for (int i = 0; i < 8; i++)
            data_op(32'h3000 + 128 * i + 4 * (i % 4), 1'b1, $urandom, 4'hf, 1'b0);
        for (int i = 0; i < 8; i++)
            data_op(32'h3000 + 128 * i + 4 * (i % 4), 1'b0, '0, '0, 1'b0);

        data_op('0, 1'b0, '0, '0, 1'b1);
        foreach (written[i]) begin
            assert (u_mem.line_at(written[i] << 4) == shadow_line(written[i] << 4))
            else begin
                errors++;
                $display("** Error: memory line %h holds %h expected %h", written[i] << 4,
                         u_mem.line_at(written[i] << 4), shadow_line(written[i] << 4));
            end
        end

        fetch('0, 1'b1);
        repeat (8)
            fetch(32'h1000 | ($urandom & 32'hfc), 1'b0);

        repeat (4) @(posedge clk);
        $display("testbench errors %0d, memory errors %0d", errors, mem_errors);
        if (errors + mem_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== l1_l2_cache.f ====
+incdir+include
source/cache_pkg.sv
source/set_sweep_counter.sv
source/l2_array.sv
source/l2_ctrl_fsm.sv
source/icache.sv
source/dcache.sv
source/l1_l2_cache.sv
tests/mem_model.sv
tests/tb_l1_l2_cache.sv
